//--- common/rv_pkg.sv
package rv_pkg;

  // Architectural register index, x0 through x31
  typedef logic [4:0] reg_idx_t;

  // Where the instruction in MEM gets its writeback value from
  typedef enum logic [2:0] {
    // Integer ALU result, ready in MEM
    RES_ALU = 3'd0,
    // Load data from the data memory
    RES_MEM = 3'd1,
    // CSR read value, only valid once it reaches WB
    RES_CSR = 3'd2,
    // Multiply/divide result from the two-stage M unit
    RES_M   = 3'd3,
    // Link address for JAL/JALR
    RES_PC4 = 3'd4
  } res_src_e;

  // Data memory read timing
  typedef enum logic {
    // Load data returns within the MEM stage
    MEM_SRAM = 1'b0,
    // Registered read, load data appears only in WB
    MEM_BRAM = 1'b1
  } mem_type_e;

endpackage

//--- common/rv_fwd_src_if.sv
`timescale 1ns/10ps

interface rv_fwd_src_if #(
  parameter int XLEN = 32
);

  // Destination register of the MEM instruction
  rv_pkg::reg_idx_t rd;
  // MEM instruction writes rd
  logic             reg_write;
  // Result source, decides whether the value can be forwarded yet
  rv_pkg::res_src_e res_src;
  // ALU or link value computed before MEM
  logic [XLEN-1:0]  result;
  // Load return data, only meaningful with SRAM timing
  logic [XLEN-1:0]  load_data;

  // Driven from the top level MEM ports
  modport src (
    output rd,
    output reg_write,
    output res_src,
    output result,
    output load_data
  );

  // Forwarding and hazard logic only look
  modport sink (
    input rd,
    input reg_write,
    input res_src,
    input result,
    input load_data
  );

endinterface

//--- source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile #(
  parameter int XLEN = 32
) (
  input  logic             clk,
  input  logic             reset,

  // ID read ports
  input  rv_pkg::reg_idx_t rs1_id,
  input  rv_pkg::reg_idx_t rs2_id,
  output logic [XLEN-1:0]  rs1_data,
  output logic [XLEN-1:0]  rs2_data,

  // WB write port
  input  rv_pkg::reg_idx_t rd_wb,
  input  logic             reg_write_wb,
  input  logic [XLEN-1:0]  rd_data_wb
);

  // One entry per architectural register
  localparam int NUM_REGS = 2 ** $bits(rv_pkg::reg_idx_t);

  logic [XLEN-1:0] regs [NUM_REGS];
  logic            wr_en;

  // x0 is never written
  assign wr_en = reg_write_wb && (rd_wb != '0);

  // Write at the clock edge
  // A same-cycle reader sees the old value, the forwarding unit covers that
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_wb] <= rd_data_wb;
    end
  end

  // Asynchronous reads
  // x0 forced to zero on the read side as well
  always_comb begin
    if (rs1_id == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_id];
    end
  end

  always_comb begin
    if (rs2_id == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_id];
    end
  end

endmodule

//--- forward/rv_fwd_id.sv
`timescale 1ns/10ps

module rv_fwd_id #(
  parameter int                XLEN     = 32,
  parameter rv_pkg::mem_type_e MEM_TYPE = rv_pkg::MEM_SRAM
) (
  // ID source indices and register file data
  input  rv_pkg::reg_idx_t rs1_id,
  input  rv_pkg::reg_idx_t rs2_id,
  input  logic [XLEN-1:0]  rs1_data_id,
  input  logic [XLEN-1:0]  rs2_data_id,

  // MEM stage source
  rv_fwd_src_if.sink       mem,

  // WB stage source
  input  rv_pkg::reg_idx_t rd_wb,
  input  logic             reg_write_wb,
  input  logic [XLEN-1:0]  rd_data_wb,

  // Resolved operands
  output logic [XLEN-1:0]  fwd_rs1_id,
  output logic [XLEN-1:0]  fwd_rs2_id
);

  logic mem_wr;
  logic is_load_mem;
  logic is_late_mem;

  // Writing MEM instruction with a real destination
  assign mem_wr      = mem.reg_write && (mem.rd != '0);
  assign is_load_mem = (mem.res_src == rv_pkg::RES_MEM);
  // CSR and multiply values are not ready in MEM
  assign is_late_mem = (mem.res_src == rv_pkg::RES_CSR) ||
                       (mem.res_src == rv_pkg::RES_M);

  // MEM result forwarding, loads and late results excluded
  logic mem_fwd_rs1;
  logic mem_fwd_rs2;

  assign mem_fwd_rs1 = mem_wr && !is_load_mem && !is_late_mem && (mem.rd == rs1_id);
  assign mem_fwd_rs2 = mem_wr && !is_load_mem && !is_late_mem && (mem.rd == rs2_id);

  // WB forwarding covers the write that lands at the coming edge
  logic wb_fwd_rs1;
  logic wb_fwd_rs2;

  assign wb_fwd_rs1 = reg_write_wb && (rd_wb != '0) && (rd_wb == rs1_id);
  assign wb_fwd_rs2 = reg_write_wb && (rd_wb != '0) && (rd_wb == rs2_id);

  if (MEM_TYPE == rv_pkg::MEM_SRAM) begin : g_sram_load_fwd
    // Load data already back in MEM
    logic load_fwd_rs1;
    logic load_fwd_rs2;

    assign load_fwd_rs1 = mem_wr && is_load_mem && (mem.rd == rs1_id);
    assign load_fwd_rs2 = mem_wr && is_load_mem && (mem.rd == rs2_id);

    // MEM load first, then MEM result, then WB, then regfile
    always_comb begin
      case (1'b1)
        load_fwd_rs1: fwd_rs1_id = mem.load_data;
        mem_fwd_rs1:  fwd_rs1_id = mem.result;
        wb_fwd_rs1:   fwd_rs1_id = rd_data_wb;
        default:      fwd_rs1_id = rs1_data_id;
      endcase
    end

    always_comb begin
      case (1'b1)
        load_fwd_rs2: fwd_rs2_id = mem.load_data;
        mem_fwd_rs2:  fwd_rs2_id = mem.result;
        wb_fwd_rs2:   fwd_rs2_id = rd_data_wb;
        default:      fwd_rs2_id = rs2_data_id;
      endcase
    end

  end else begin : g_bram_no_load_fwd
    // Load in MEM has no data yet
    // the hazard unit stalls on it instead
    always_comb begin
      case (1'b1)
        mem_fwd_rs1: fwd_rs1_id = mem.result;
        wb_fwd_rs1:  fwd_rs1_id = rd_data_wb;
        default:     fwd_rs1_id = rs1_data_id;
      endcase
    end

    always_comb begin
      case (1'b1)
        mem_fwd_rs2: fwd_rs2_id = mem.result;
        wb_fwd_rs2:  fwd_rs2_id = rd_data_wb;
        default:     fwd_rs2_id = rs2_data_id;
      endcase
    end
  end

endmodule

//--- forward/rv_hazard_id.sv
`timescale 1ns/10ps

module rv_hazard_id #(
  parameter rv_pkg::mem_type_e MEM_TYPE = rv_pkg::MEM_SRAM
) (
  input  logic             id_valid,
  input  rv_pkg::reg_idx_t rs1_id,
  input  rv_pkg::reg_idx_t rs2_id,

  // MEM stage source
  rv_fwd_src_if.sink       mem,

  // Hold ID until MEM and WB move on
  output logic             stall
);

  // With BRAM timing a load in MEM has no data to forward
  localparam bit LOAD_LATE = (MEM_TYPE == rv_pkg::MEM_BRAM);

  logic mem_wr;
  logic src_match;
  logic late_result;

  // Only a real write to x1..x31 can create a dependency
  assign mem_wr = mem.reg_write && (mem.rd != '0);

  // Either ID source reads the MEM destination
  assign src_match = (mem.rd == rs1_id) || (mem.rd == rs2_id);

  // Result sources that cannot be forwarded from MEM
  always_comb begin
    case (mem.res_src)
      rv_pkg::RES_CSR: late_result = 1'b1;
      rv_pkg::RES_M:   late_result = 1'b1;
      rv_pkg::RES_MEM: late_result = LOAD_LATE;
      default:         late_result = 1'b0;
    endcase
  end

  // Stall only for a valid instruction in ID
  assign stall = id_valid && mem_wr && src_match && late_result;

endmodule

//--- source/rv_id_ex_reg.sv
`timescale 1ns/10ps

module rv_id_ex_reg #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            reset,

  // ID side
  input  logic            id_valid,
  input  logic            stall,
  input  logic [XLEN-1:0] fwd_rs1_id,
  input  logic [XLEN-1:0] fwd_rs2_id,

  // EX side
  output logic            ex_valid,
  output logic [XLEN-1:0] ex_rs1,
  output logic [XLEN-1:0] ex_rs2
);

  logic capture;

  // Advance whenever ID holds a valid instruction and no hazard is open
  assign capture = id_valid && !stall;

  // Bubble on stall or empty ID
  // operands just hold in that case
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
      ex_rs1   <= '0;
      ex_rs2   <= '0;
    end else begin
      ex_valid <= capture;
      if (capture) begin
        ex_rs1 <= fwd_rs1_id;
        ex_rs2 <= fwd_rs2_id;
      end
    end
  end

endmodule

//--- source/rv_operand_read.sv
`timescale 1ns/10ps

module rv_operand_read #(
  parameter int                XLEN     = 32,
  parameter rv_pkg::mem_type_e MEM_TYPE = rv_pkg::MEM_SRAM
) (
  input  logic             clk,
  input  logic             reset,

  // ID stage
  input  logic             id_valid,
  input  rv_pkg::reg_idx_t rs1_id,
  input  rv_pkg::reg_idx_t rs2_id,

  // MEM stage
  input  rv_pkg::reg_idx_t rd_mem,
  input  logic             reg_write_mem,
  input  rv_pkg::res_src_e res_src_mem,
  input  logic [XLEN-1:0]  result_mem,
  input  logic [XLEN-1:0]  load_data_mem,

  // WB stage
  input  rv_pkg::reg_idx_t rd_wb,
  input  logic             reg_write_wb,
  input  logic [XLEN-1:0]  rd_data_wb,

  // Handshake and EX operands
  output logic             stall,
  output logic             ex_valid,
  output logic [XLEN-1:0]  ex_rs1,
  output logic [XLEN-1:0]  ex_rs2
);

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] fwd_rs1;
  logic [XLEN-1:0] fwd_rs2;

  // MEM source bundle shared by forwarding and hazard logic
  rv_fwd_src_if #(.XLEN(XLEN)) mem_fwd ();

  assign mem_fwd.rd        = rd_mem;
  assign mem_fwd.reg_write = reg_write_mem;
  assign mem_fwd.res_src   = res_src_mem;
  assign mem_fwd.result    = result_mem;
  assign mem_fwd.load_data = load_data_mem;

  rv_regfile #(
    .XLEN(XLEN)
  ) u_regfile (
    .clk          (clk),
    .reset        (reset),
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rd_wb        (rd_wb),
    .reg_write_wb (reg_write_wb),
    .rd_data_wb   (rd_data_wb)
  );

  rv_fwd_id #(
    .XLEN     (XLEN),
    .MEM_TYPE (MEM_TYPE)
  ) u_fwd_id (
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_data_id  (rs1_data),
    .rs2_data_id  (rs2_data),
    .mem          (mem_fwd.sink),
    .rd_wb        (rd_wb),
    .reg_write_wb (reg_write_wb),
    .rd_data_wb   (rd_data_wb),
    .fwd_rs1_id   (fwd_rs1),
    .fwd_rs2_id   (fwd_rs2)
  );

  rv_hazard_id #(
    .MEM_TYPE (MEM_TYPE)
  ) u_hazard_id (
    .id_valid (id_valid),
    .rs1_id   (rs1_id),
    .rs2_id   (rs2_id),
    .mem      (mem_fwd.sink),
    .stall    (stall)
  );

  rv_id_ex_reg #(
    .XLEN(XLEN)
  ) u_id_ex_reg (
    .clk        (clk),
    .reset      (reset),
    .id_valid   (id_valid),
    .stall      (stall),
    .fwd_rs1_id (fwd_rs1),
    .fwd_rs2_id (fwd_rs2),
    .ex_valid   (ex_valid),
    .ex_rs1     (ex_rs1),
    .ex_rs2     (ex_rs2)
  );

endmodule

//--- testbench/rv_operand_read_asserts.sv
`timescale 1ns/10ps

module rv_operand_read_asserts #(
  parameter int XLEN = 32
) (
  input logic             clk,
  input logic             reset,
  input logic             id_valid,
  input rv_pkg::reg_idx_t rs1_id,
  input rv_pkg::reg_idx_t rs2_id,
  input logic             stall,
  input logic             ex_valid,
  input logic [XLEN-1:0]  ex_rs1,
  input logic [XLEN-1:0]  ex_rs2
);

  // A stalled ID slot becomes a bubble in EX
  a_stall_bubble: assert property (
    @(posedge clk) disable iff (reset) stall |=> !ex_valid
  ) else $error("ex_valid high in the cycle after a stall");

  // EX is empty once reset has been sampled
  a_reset_empty: assert property (
    @(posedge clk) reset |=> !ex_valid
  ) else $error("ex_valid high after reset");

  // x0 sources never pick up a forwarded value
  a_x0_rs1: assert property (
    @(posedge clk) disable iff (reset)
      (id_valid && !stall && (rs1_id == '0)) |=> (ex_rs1 == '0)
  ) else $error("rs1 of x0 captured a nonzero operand");

  a_x0_rs2: assert property (
    @(posedge clk) disable iff (reset)
      (id_valid && !stall && (rs2_id == '0)) |=> (ex_rs2 == '0)
  ) else $error("rs2 of x0 captured a nonzero operand");

endmodule

// Attach to every instance of the slice top level
bind rv_operand_read rv_operand_read_asserts #(
  .XLEN(XLEN)
) u_asserts (
  .clk      (clk),
  .reset    (reset),
  .id_valid (id_valid),
  .rs1_id   (rs1_id),
  .rs2_id   (rs2_id),
  .stall    (stall),
  .ex_valid (ex_valid),
  .ex_rs1   (ex_rs1),
  .ex_rs2   (ex_rs2)
);

//--- testbench/rv_operand_read_tb.sv
`timescale 1ns/10ps

module rv_operand_read_tb;

  localparam int XLEN            = 32;
  localparam int CLK_PERIOD      = 8;
  // Full sequence is about 110 cycles
  localparam int WATCHDOG_CYCLES = 300;

  logic             clk = 1'b0;
  logic             reset;
  logic             id_valid;
  rv_pkg::reg_idx_t rs1_id;
  rv_pkg::reg_idx_t rs2_id;
  rv_pkg::reg_idx_t rd_mem;
  logic             reg_write_mem;
  rv_pkg::res_src_e res_src_mem;
  logic [XLEN-1:0]  result_mem;
  logic [XLEN-1:0]  load_data_mem;
  rv_pkg::reg_idx_t rd_wb;
  logic             reg_write_wb;
  logic [XLEN-1:0]  rd_data_wb;
  logic             stall;
  logic             ex_valid;
  logic [XLEN-1:0]  ex_rs1;
  logic [XLEN-1:0]  ex_rs2;

  // Register contents as the testbench expects them
  logic [XLEN-1:0]  shadow [32];
  // Operands the EX register should hold after the last capture
  logic [XLEN-1:0]  held_rs1;
  logic [XLEN-1:0]  held_rs2;
  integer           seed;
  int               errors;

  rv_operand_read #(
    .XLEN     (XLEN),
    .MEM_TYPE (rv_pkg::MEM_SRAM)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .id_valid      (id_valid),
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .rd_mem        (rd_mem),
    .reg_write_mem (reg_write_mem),
    .res_src_mem   (res_src_mem),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .rd_wb         (rd_wb),
    .reg_write_wb  (reg_write_wb),
    .rd_data_wb    (rd_data_wb),
    .stall         (stall),
    .ex_valid      (ex_valid),
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_operand(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic set_mem(input rv_pkg::reg_idx_t rd, input logic we,
                         input rv_pkg::res_src_e src, input logic [XLEN-1:0] result,
                         input logic [XLEN-1:0] load);
    rd_mem        = rd;
    reg_write_mem = we;
    res_src_mem   = src;
    result_mem    = result;
    load_data_mem = load;
  endtask

  task automatic set_wb(input rv_pkg::reg_idx_t rd, input logic we,
                        input logic [XLEN-1:0] data);
    rd_wb        = rd;
    reg_write_wb = we;
    rd_data_wb   = data;
  endtask

  // Idle ID, MEM and WB
  task automatic clear_stages();
    id_valid = 1'b0;
    rs1_id   = '0;
    rs2_id   = '0;
    set_mem('0, 1'b0, rv_pkg::RES_ALU, '0, '0);
    set_wb('0, 1'b0, '0);
  endtask

  // Priority: MEM load, MEM result, WB, register file
  function automatic logic [XLEN-1:0] expected_operand(input rv_pkg::reg_idx_t idx);
    logic [XLEN-1:0] value;
    logic            mem_hit;
    value   = shadow[idx];
    mem_hit = reg_write_mem && (rd_mem == idx);
    if (idx == '0) begin
      value = '0;
    end else if (mem_hit && (res_src_mem == rv_pkg::RES_MEM)) begin
      value = load_data_mem;
    end else if (mem_hit && (res_src_mem != rv_pkg::RES_CSR) &&
                 (res_src_mem != rv_pkg::RES_M)) begin
      value = result_mem;
    end else if (reg_write_wb && (rd_wb == idx)) begin
      value = rd_data_wb;
    end
    return value;
  endfunction

  // One ID instruction against the MEM and WB values already driven
  task automatic read_pair(input rv_pkg::reg_idx_t rs1, input rv_pkg::reg_idx_t rs2,
                           input logic stall_exp);
    logic [XLEN-1:0] exp_rs1;
    logic [XLEN-1:0] exp_rs2;
    id_valid = 1'b1;
    rs1_id   = rs1;
    rs2_id   = rs2;
    #1;
    check_flag("stall", stall_exp, stall);
    // Stalled pair leaves the EX operands as they are
    exp_rs1 = stall_exp ? held_rs1 : expected_operand(rs1);
    exp_rs2 = stall_exp ? held_rs2 : expected_operand(rs2);
    @(posedge clk);
    #1;
    if (reg_write_wb && (rd_wb != '0)) begin
      shadow[rd_wb] = rd_data_wb;
    end
    check_flag("ex_valid", !stall_exp, ex_valid);
    check_operand("ex_rs1", exp_rs1, ex_rs1);
    check_operand("ex_rs2", exp_rs2, ex_rs2);
    held_rs1 = exp_rs1;
    held_rs2 = exp_rs2;
    clear_stages();
  endtask

  // Behavior 5, also run first to bring the slice up
  task automatic test_reset();
    reset = 1'b1;
    clear_stages();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    held_rs1 = '0;
    held_rs2 = '0;
    check_flag("ex_valid", 1'b0, ex_valid);
    check_operand("ex_rs1", '0, ex_rs1);
    check_operand("ex_rs2", '0, ex_rs2);
    for (int i = 0; i < 16; i++) begin
      read_pair(rv_pkg::reg_idx_t'(i), rv_pkg::reg_idx_t'(i + 16), 1'b0);
    end
  endtask

  // Behavior 1, fill through WB while ID is idle, then read back
  task automatic test_register_read();
    for (int i = 1; i < 32; i++) begin
      set_wb(rv_pkg::reg_idx_t'(i), 1'b1, $random(seed));
      @(posedge clk);
      #1;
      shadow[i] = rd_data_wb;
      clear_stages();
    end
    for (int i = 0; i < 32; i++) begin
      read_pair(rv_pkg::reg_idx_t'(i), rv_pkg::reg_idx_t'(31 - i), 1'b0);
    end
  endtask

  // Behavior 2
  task automatic test_wb_forward();
    set_wb(5'd5, 1'b1, $random(seed));
    read_pair(5'd5, 5'd7, 1'b0);
    // x0 write dropped
    set_wb('0, 1'b1, 32'hdead_beef);
    read_pair('0, 5'd5, 1'b0);
    read_pair('0, '0, 1'b0);
  endtask

  // Behavior 3
  task automatic test_mem_forward();
    set_mem(5'd6, 1'b1, rv_pkg::RES_ALU, $random(seed), $random(seed));
    set_wb(5'd6, 1'b1, $random(seed));
    read_pair(5'd6, 5'd6, 1'b0);
    set_mem(5'd9, 1'b1, rv_pkg::RES_MEM, $random(seed), $random(seed));
    read_pair(5'd9, 5'd3, 1'b0);
    set_mem(5'd4, 1'b1, rv_pkg::RES_PC4, $random(seed), $random(seed));
    read_pair(5'd2, 5'd4, 1'b0);
    // Non-writing MEM instruction, WB supplies the value
    set_mem(5'd8, 1'b0, rv_pkg::RES_ALU, $random(seed), $random(seed));
    set_wb(5'd8, 1'b1, $random(seed));
    read_pair(5'd8, 5'd1, 1'b0);
  endtask

  // Behavior 4
  task automatic test_stall();
    set_mem(5'd10, 1'b1, rv_pkg::RES_CSR, $random(seed), $random(seed));
    read_pair(5'd10, 5'd1, 1'b1);
    set_mem(5'd11, 1'b1, rv_pkg::RES_M, $random(seed), $random(seed));
    read_pair(5'd2, 5'd11, 1'b1);
    set_mem(5'd12, 1'b1, rv_pkg::RES_CSR, $random(seed), $random(seed));
    read_pair(5'd13, 5'd14, 1'b0);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  initial begin
    seed   = 10;
    errors = 0;
    test_reset();
    test_register_read();
    test_wb_forward();
    test_mem_forward();
    test_stall();
    // Second reset clears a filled register file
    test_reset();
    $display("checks complete with %0d errors", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- files.f
common/rv_pkg.sv
common/rv_fwd_src_if.sv
source/rv_regfile.sv
forward/rv_fwd_id.sv
forward/rv_hazard_id.sv
source/rv_id_ex_reg.sv
source/rv_operand_read.sv
testbench/rv_operand_read_asserts.sv
testbench/rv_operand_read_tb.sv

//--- Makefile
# Verilator build for the operand-read slice
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= rv_operand_read_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the verdict, the exit status of the model is not used
run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "FAIL, no verdict in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
